// ==== pkg_instructions.sv ====
package pkg_instructions;

	// Major opcodes of the supported RV32 subset
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		STORE  = 7'b0100011
	} opcode_e;

	// funct3 codes
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SW      = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 codes, SUB differs only in bit 30
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;

	// ALU operations
	typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, PASS_B} alu_op_e;

	// Register-register format
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	// Immediate format
	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	// Store format, immediate split around rs2/rs1
	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_type_t;

	// One instruction word, three views
	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
	} instr_u;

	// L1.5 request types
	localparam logic [4:0] RQ_LOAD  = 5'd0;
	localparam logic [4:0] RQ_STORE = 5'd1;

	// L1.5 return types, low bits of returntype
	localparam logic [3:0] RET_LOAD   = 4'b0000;
	localparam logic [3:0] RET_ST_ACK = 4'b0100;
	localparam logic [3:0] RET_INT    = 4'b0111;

	// Request size for 4 bytes
	localparam logic [2:0] SIZE_WORD = 3'b010;

endpackage

// ==== core_mem_if.sv ====
`timescale 1ns/1ps

interface core_mem_if #(
	parameter int XLEN = 32
);

	// Fetched instruction, one-cycle pulse with its word
	logic                        instr_valid;
	pkg_instructions::instr_u    instr;

	// Store request, level until store_done
	logic                        store_valid;
	logic [XLEN-1:0]             store_addr;
	logic [XLEN-1:0]             store_data;
	logic                        store_done;

	// Instruction finished, PC may advance
	logic                        retire;

	// L1.5 side
	modport transducer (
		output instr_valid,
		output instr,
		output store_done,
		input  store_valid,
		input  store_addr,
		input  store_data,
		input  retire
	);

	// Execute side
	modport pipe (
		input  store_done,
		output store_valid,
		output store_addr,
		output store_data,
		output retire
	);

endinterface

// ==== l15_transducer.sv ====
`timescale 1ns/1ps

module l15_transducer #(
	parameter int              XLEN     = 32,
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_1000
) (
	input  logic            clk,
	input  logic            nrst,
	input  logic            l15_transducer_ack,
	input  logic            l15_transducer_header_ack,
	input  logic            l15_transducer_val,
	input  logic [63:0]     l15_transducer_data_0,
	input  logic [63:0]     l15_transducer_data_1,
	input  logic [31:0]     l15_transducer_returntype,
	output logic [4:0]      transducer_l15_rqtype,
	output logic [2:0]      transducer_l15_size,
	output logic [XLEN-1:0] transducer_l15_address,
	output logic [XLEN-1:0] transducer_l15_data,
	output logic            transducer_l15_val,
	output logic            transducer_l15_req_ack,
	core_mem_if.transducer  mem
);

	// SLEEP must stay at zero, the checker looks for it
	typedef enum logic [2:0] {
		SLEEP      = 3'd0,
		FETCH_REQ  = 3'd1,
		FETCH_WAIT = 3'd2,
		IDLE       = 3'd3,
		STORE_REQ  = 3'd4,
		STORE_WAIT = 3'd5
	} state_e;

	state_e          state;
	logic [XLEN-1:0] pc;
	logic            resp_new;
	logic [3:0]      ret_type;
	logic [31:0]     fetch_word;
	logic            fetch_launch;
	logic            store_launch;
	logic [XLEN-1:0] fetch_addr;

	// New response, L1.5 keeps val up through our req_ack cycle
	assign resp_new = l15_transducer_val && !transducer_l15_req_ack;
	// Only the low nibble carries the type
	assign ret_type = l15_transducer_returntype[3:0];

	// Word lane picked by PC bits 3:2
	always_comb
	begin
		case (pc[3:2])
			2'b00:   fetch_word = l15_transducer_data_0[31:0];
			2'b01:   fetch_word = l15_transducer_data_0[63:32];
			2'b10:   fetch_word = l15_transducer_data_1[31:0];
			default: fetch_word = l15_transducer_data_1[63:32];
		endcase
	end

	// Fetch goes out straight after retire, or after wake-up from FETCH_REQ
	assign fetch_launch = (state == FETCH_REQ && !transducer_l15_val) ||
		(state == IDLE && mem.retire);
	assign fetch_addr = (state == IDLE) ? pc + 4 : pc;
	// store_done cycle still sees store_valid, skip it
	assign store_launch = state == IDLE && !mem.retire && mem.store_valid && !mem.store_done;

	// Always whole words
	assign transducer_l15_size = pkg_instructions::SIZE_WORD;

	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			state <= SLEEP;
			pc <= RESET_PC;
			transducer_l15_val <= 1'b0;
			transducer_l15_req_ack <= 1'b0;
			mem.instr_valid <= 1'b0;
			mem.store_done <= 1'b0;
		end
		else
		begin
			// Every response gets one req_ack pulse
			transducer_l15_req_ack <= resp_new;
			mem.instr_valid <= 1'b0;
			mem.store_done <= 1'b0;
			if (fetch_launch || store_launch)
				transducer_l15_val <= 1'b1;
			case (state)
				SLEEP:
				begin
					// Other return types are acked and dropped
					if (resp_new && ret_type == pkg_instructions::RET_INT)
						state <= FETCH_REQ;
				end
				FETCH_REQ:
				begin
					if (transducer_l15_val && l15_transducer_header_ack)
					begin
						transducer_l15_val <= 1'b0;
						state <= FETCH_WAIT;
					end
				end
				FETCH_WAIT:
				begin
					if (resp_new && ret_type == pkg_instructions::RET_LOAD)
					begin
						mem.instr_valid <= 1'b1;
						state <= IDLE;
					end
				end
				IDLE:
				begin
					if (fetch_launch)
					begin
						pc <= fetch_addr;
						state <= FETCH_REQ;
					end
					else if (store_launch)
						state <= STORE_REQ;
				end
				STORE_REQ:
				begin
					if (l15_transducer_header_ack)
					begin
						transducer_l15_val <= 1'b0;
						state <= STORE_WAIT;
					end
				end
				STORE_WAIT:
				begin
					if (resp_new && ret_type == pkg_instructions::RET_ST_ACK)
					begin
						mem.store_done <= 1'b1;
						state <= IDLE;
					end
				end
				default:
					state <= SLEEP;
			endcase
		end
	end

	// Request payload, only written while val is low
	always_ff @(posedge clk)
	begin
		if (fetch_launch)
		begin
			transducer_l15_rqtype <= pkg_instructions::RQ_LOAD;
			transducer_l15_address <= fetch_addr;
			transducer_l15_data <= '0;
		end
		else if (store_launch)
		begin
			transducer_l15_rqtype <= pkg_instructions::RQ_STORE;
			transducer_l15_address <= mem.store_addr;
			transducer_l15_data <= mem.store_data;
		end
		// Instruction word, valid with instr_valid
		if (state == FETCH_WAIT && resp_new)
			mem.instr <= fetch_word;
	end

endmodule

// ==== instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode (
	input  logic                      clk,
	input  logic                      nrst,
	input  logic                      instr_valid,
	input  pkg_instructions::instr_u  instr,
	output logic                      op_valid,
	output pkg_instructions::alu_op_e alu_op,
	output logic                      use_imm,
	output logic                      is_store,
	output logic [4:0]                rs1,
	output logic [4:0]                rs2,
	output logic [4:0]                rd,
	output logic [31:0]               imm
);

	pkg_instructions::alu_op_e d_alu_op;
	logic                      d_use_imm;
	logic                      d_is_store;
	logic [4:0]                d_rs1;
	logic [4:0]                d_rs2;
	logic [4:0]                d_rd;
	logic [31:0]               d_imm;

	always_comb
	begin
		// Default is a no-op, PASS_B into x0
		d_alu_op = pkg_instructions::PASS_B;
		d_use_imm = 1'b1;
		d_is_store = 1'b0;
		d_rs1 = 5'd0;
		d_rs2 = 5'd0;
		d_rd = 5'd0;
		d_imm = '0;
		case (instr.r.opcode)
			pkg_instructions::OP_IMM:
			begin
				d_rs1 = instr.i.rs1;
				d_rd = instr.i.rd;
				d_imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
				case (instr.i.funct3)
					pkg_instructions::F3_ADD_SUB: d_alu_op = pkg_instructions::ADD;
					pkg_instructions::F3_XOR:     d_alu_op = pkg_instructions::XOR;
					pkg_instructions::F3_OR:      d_alu_op = pkg_instructions::OR;
					pkg_instructions::F3_AND:     d_alu_op = pkg_instructions::AND;
					// SLTI, shifts etc. dropped
					default:                      d_rd = 5'd0;
				endcase
			end
			pkg_instructions::OP:
			begin
				d_rs1 = instr.r.rs1;
				d_rs2 = instr.r.rs2;
				d_rd = instr.r.rd;
				d_use_imm = 1'b0;
				if (instr.r.funct7 == pkg_instructions::F7_SUB &&
					instr.r.funct3 == pkg_instructions::F3_ADD_SUB)
					d_alu_op = pkg_instructions::SUB;
				else if (instr.r.funct7 != pkg_instructions::F7_BASE)
					d_rd = 5'd0;
				else
				begin
					case (instr.r.funct3)
						pkg_instructions::F3_ADD_SUB: d_alu_op = pkg_instructions::ADD;
						pkg_instructions::F3_XOR:     d_alu_op = pkg_instructions::XOR;
						pkg_instructions::F3_OR:      d_alu_op = pkg_instructions::OR;
						pkg_instructions::F3_AND:     d_alu_op = pkg_instructions::AND;
						default:                      d_rd = 5'd0;
					endcase
				end
			end
			pkg_instructions::LUI:
			begin
				// Upper 20 bits read through the R view
				d_rd = instr.r.rd;
				d_imm = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'h000};
			end
			pkg_instructions::STORE:
			begin
				// Address comes out of the ALU as rs1 + imm
				d_rs1 = instr.s.rs1;
				d_rs2 = instr.s.rs2;
				d_imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
				d_alu_op = pkg_instructions::ADD;
				// SB and SH retire as no-ops
				d_is_store = instr.s.funct3 == pkg_instructions::F3_SW;
			end
			default:
				d_rd = 5'd0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!nrst)
			op_valid <= 1'b0;
		else
			op_valid <= instr_valid;
	end

	// Fields held until the next instruction
	always_ff @(posedge clk)
	begin
		if (instr_valid)
		begin
			alu_op <= d_alu_op;
			use_imm <= d_use_imm;
			is_store <= d_is_store;
			rs1 <= d_rs1;
			rs2 <= d_rs2;
			rd <= d_rd;
			imm <= d_imm;
		end
	end

endmodule

// ==== execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit #(
	parameter int XLEN = 32
) (
	input  logic                      clk,
	input  logic                      nrst,
	input  logic                      op_valid,
	input  pkg_instructions::alu_op_e alu_op,
	input  logic                      use_imm,
	input  logic                      is_store,
	input  logic [4:0]                rs1,
	input  logic [4:0]                rs2,
	input  logic [4:0]                rd,
	input  logic [31:0]               imm,
	core_mem_if.pipe                  mem
);

	// x1..x31, x0 is hardwired
	logic [XLEN-1:0] regs [1:31];
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] operand_b;
	logic [XLEN-1:0] result;
	logic            store_pending;
	logic            store_retire;

	// Register reads, x0 reads zero
	assign rs1_val = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == 5'd0) ? '0 : regs[rs2];
	assign operand_b = use_imm ? imm : rs2_val;

	always_comb
	begin
		case (alu_op)
			pkg_instructions::ADD: result = rs1_val + operand_b;
			pkg_instructions::SUB: result = rs1_val - operand_b;
			pkg_instructions::AND: result = rs1_val & operand_b;
			pkg_instructions::OR:  result = rs1_val | operand_b;
			pkg_instructions::XOR: result = rs1_val ^ operand_b;
			// PASS_B, LUI and no-ops
			default:               result = operand_b;
		endcase
	end

	// Write-back in the op_valid cycle
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (op_valid && !is_store && rd != 5'd0)
			regs[rd] <= result;
	end

	// Store stays pending until the transducer reports the ack
	always_ff @(posedge clk)
	begin
		if (!nrst)
		begin
			store_pending <= 1'b0;
			store_retire <= 1'b0;
		end
		else
		begin
			store_retire <= mem.store_done;
			if (op_valid && is_store)
				store_pending <= 1'b1;
			else if (mem.store_done)
				store_pending <= 1'b0;
		end
	end

	// Rises with op_valid, falls the cycle after store_done
	assign mem.store_valid = store_pending || (op_valid && is_store);
	// Decoder fields are held, so these stay stable
	assign mem.store_addr = result;
	assign mem.store_data = rs2_val;

	// ALU ops retire at once, stores one cycle after store_done
	assign mem.retire = (op_valid && !is_store) || store_retire;

endmodule

// ==== core.sv ====
`timescale 1ns/1ps

module core #(
	parameter int              XLEN     = 32,
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_1000
) (
	input  logic        clk,
	input  logic        nrst,
	input  logic        l15_transducer_ack,
	input  logic        l15_transducer_header_ack,
	input  logic        l15_transducer_val,
	input  logic [63:0] l15_transducer_data_0,
	input  logic [63:0] l15_transducer_data_1,
	input  logic [31:0] l15_transducer_returntype,
	output logic [4:0]  transducer_l15_rqtype,
	output logic [2:0]  transducer_l15_size,
	output logic [31:0] transducer_l15_address,
	output logic [31:0] transducer_l15_data,
	output logic        transducer_l15_val,
	output logic        transducer_l15_req_ack
);

	// Decoder to execute
	logic                      op_valid;
	pkg_instructions::alu_op_e alu_op;
	logic                      use_imm;
	logic                      is_store;
	logic [4:0]                rs1;
	logic [4:0]                rs2;
	logic [4:0]                rd;
	logic [31:0]               imm;

	core_mem_if #(.XLEN(XLEN)) mem ();

	// L1.5 port and PC
	l15_transducer #(
		.XLEN     (XLEN),
		.RESET_PC (RESET_PC)
	) transducer (
		.clk                       (clk),
		.nrst                      (nrst),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.l15_transducer_returntype (l15_transducer_returntype),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_req_ack    (transducer_l15_req_ack),
		.mem                       (mem.transducer)
	);

	// Fetched word straight from the interface
	instr_decode decoder (
		.clk         (clk),
		.nrst        (nrst),
		.instr_valid (mem.instr_valid),
		.instr       (mem.instr),
		.op_valid    (op_valid),
		.alu_op      (alu_op),
		.use_imm     (use_imm),
		.is_store    (is_store),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd          (rd),
		.imm         (imm)
	);

	execute_unit #(.XLEN(XLEN)) exec (
		.clk      (clk),
		.nrst     (nrst),
		.op_valid (op_valid),
		.alu_op   (alu_op),
		.use_imm  (use_imm),
		.is_store (is_store),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.imm      (imm),
		.mem      (mem.pipe)
	);

endmodule

// ==== core_checker.sv ====
`timescale 1ns/1ps

module core_checker (
	input logic        clk,
	input logic        nrst,
	input logic        transducer_l15_val,
	input logic        l15_transducer_header_ack,
	input logic [4:0]  transducer_l15_rqtype,
	input logic [2:0]  transducer_l15_size,
	input logic [31:0] transducer_l15_address,
	input logic [31:0] transducer_l15_data,
	input logic        l15_transducer_val,
	input logic        transducer_l15_req_ack,
	input logic [2:0]  state
);

	// Pending request keeps val and payload until header_ack
	a_req_stable: assert property (@(posedge clk) disable iff (!nrst)
		(transducer_l15_val && !l15_transducer_header_ack) |=>
		(transducer_l15_val && $stable(transducer_l15_rqtype) &&
		$stable(transducer_l15_size) && $stable(transducer_l15_address) &&
		$stable(transducer_l15_data)))
		else $error("request changed before header_ack");

	// req_ack follows a cycle with response val
	a_req_ack: assert property (@(posedge clk) disable iff (!nrst)
		transducer_l15_req_ack |-> $past(l15_transducer_val))
		else $error("req_ack without a response");

	// Sleeping core is silent, SLEEP is encoded as zero
	a_sleep_quiet: assert property (@(posedge clk) disable iff (!nrst)
		(state == 3'd0) |-> !transducer_l15_val)
		else $error("request raised while asleep");

endmodule

bind l15_transducer core_checker chk (
	.clk                       (clk),
	.nrst                      (nrst),
	.transducer_l15_val        (transducer_l15_val),
	.l15_transducer_header_ack (l15_transducer_header_ack),
	.transducer_l15_rqtype     (transducer_l15_rqtype),
	.transducer_l15_size       (transducer_l15_size),
	.transducer_l15_address    (transducer_l15_address),
	.transducer_l15_data       (transducer_l15_data),
	.l15_transducer_val        (l15_transducer_val),
	.transducer_l15_req_ack    (transducer_l15_req_ack),
	.state                     (state)
);

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic nrst
);

	// 100 ns period
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset held for 4 rising edges, released just after the edge
	initial
	begin
		nrst = 1'b0;
		repeat (4) @(posedge clk);
		#5 nrst = 1'b1;
	end

endmodule

// ==== tb_core.sv ====
`timescale 1ns/1ps

module tb_core;

	localparam logic [31:0] RESET_PC = 32'h0000_1000;
	localparam int NUM_ROWS = 29;
	localparam int TIMEOUT_CYCLES = 40 * NUM_ROWS + 100;

	typedef struct {
		logic [31:0] word;
		int          test;
		logic        store;
		logic [31:0] addr;
		logic [31:0] data;
	} row_t;

	logic        clk;
	logic        nrst;
	logic        l15_transducer_ack;
	logic        l15_transducer_header_ack;
	logic        l15_transducer_val;
	logic [63:0] l15_transducer_data_0;
	logic [63:0] l15_transducer_data_1;
	logic [31:0] l15_transducer_returntype;
	logic [4:0]  transducer_l15_rqtype;
	logic [2:0]  transducer_l15_size;
	logic [31:0] transducer_l15_address;
	logic [31:0] transducer_l15_data;
	logic        transducer_l15_val;
	logic        transducer_l15_req_ack;

	row_t        rows [NUM_ROWS];
	logic [31:0] lfsr = 32'hf89c;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          cycles = 0;

	tb_clock clock_gen (
		.clk  (clk),
		.nrst (nrst)
	);

	core #(
		.XLEN     (32),
		.RESET_PC (RESET_PC)
	) i_dut (
		.clk                       (clk),
		.nrst                      (nrst),
		.l15_transducer_ack        (l15_transducer_ack),
		.l15_transducer_header_ack (l15_transducer_header_ack),
		.l15_transducer_val        (l15_transducer_val),
		.l15_transducer_data_0     (l15_transducer_data_0),
		.l15_transducer_data_1     (l15_transducer_data_1),
		.l15_transducer_returntype (l15_transducer_returntype),
		.transducer_l15_rqtype     (transducer_l15_rqtype),
		.transducer_l15_size       (transducer_l15_size),
		.transducer_l15_address    (transducer_l15_address),
		.transducer_l15_data       (transducer_l15_data),
		.transducer_l15_val        (transducer_l15_val),
		.transducer_l15_req_ack    (transducer_l15_req_ack)
	);

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// RV32 encoders
	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic row_t make_row(input logic [31:0] word, input int test,
		input logic store, input logic [31:0] addr, input logic [31:0] data);
		row_t r;
		r.word = word;
		r.test = test;
		r.store = store;
		r.addr = addr;
		r.data = data;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, expected);
		end
	endtask

	// Drive point, 5 ns after the rising edge
	task automatic step();
		@(posedge clk);
		#5;
	endtask

	task automatic wait_request();
		while (!transducer_l15_val)
			step();
	endtask

	// Random 0..3 cycle delay, then one header_ack cycle
	task automatic accept_request();
		logic [31:0] d;
		random_bits(2, d);
		repeat (d) step();
		l15_transducer_header_ack = 1'b1;
		step();
		l15_transducer_header_ack = 1'b0;
	endtask

	// Response held until req_ack is seen
	task automatic send_response(input logic [3:0] rtype, input logic [63:0] d0,
		input logic [63:0] d1);
		logic [31:0] d;
		random_bits(2, d);
		repeat (d) step();
		l15_transducer_val = 1'b1;
		l15_transducer_returntype = {28'h0, rtype};
		l15_transducer_data_0 = d0;
		l15_transducer_data_1 = d1;
		step();
		// req_ack due in the cycle after val is first sampled
		check_value("transducer_l15_req_ack", {31'b0, transducer_l15_req_ack}, 32'h1);
		while (!transducer_l15_req_ack)
			step();
		l15_transducer_val = 1'b0;
		l15_transducer_returntype = '0;
	endtask

	// 128-bit return, word in lane addr[3:2], LFSR garbage elsewhere
	task automatic make_lines(input logic [31:0] addr, input logic [31:0] word,
		output logic [63:0] d0, output logic [63:0] d1);
		logic [31:0] lane [4];
		for (int i = 0; i < 4; i++)
			random_bits(32, lane[i]);
		lane[addr[3:2]] = word;
		d0 = {lane[1], lane[0]};
		d1 = {lane[3], lane[2]};
	endtask

	task automatic load_table();
		// Test 2, immediates and LUI
		rows[0]  = make_row(enc_i(12'hFFB, 5'd0, 3'b000, 5'd1), 2, 0, 0, 0);
		rows[1]  = make_row(enc_sw(12'h100, 5'd1, 5'd0), 2, 1, 32'h100, 32'hFFFF_FFFB);
		rows[2]  = make_row(enc_i(12'hFF0, 5'd1, 3'b111, 5'd2), 2, 0, 0, 0);
		rows[3]  = make_row(enc_sw(12'h104, 5'd2, 5'd0), 2, 1, 32'h104, 32'hFFFF_FFF0);
		rows[4]  = make_row(enc_i(12'hF00, 5'd0, 3'b110, 5'd3), 2, 0, 0, 0);
		rows[5]  = make_row(enc_i(12'hFFF, 5'd3, 3'b100, 5'd3), 2, 0, 0, 0);
		rows[6]  = make_row(enc_sw(12'h108, 5'd3, 5'd0), 2, 1, 32'h108, 32'h0000_00FF);
		rows[7]  = make_row({20'h12345, 5'd4, 7'b0110111}, 2, 0, 0, 0);
		rows[8]  = make_row(enc_i(12'h678, 5'd4, 3'b000, 5'd4), 2, 0, 0, 0);
		rows[9]  = make_row(enc_sw(12'h10C, 5'd4, 5'd0), 2, 1, 32'h10C, 32'h1234_5678);
		// Test 3, register operations and x0
		rows[10] = make_row(enc_r(7'h00, 5'd1, 5'd4, 3'b000, 5'd5), 3, 0, 0, 0);
		rows[11] = make_row(enc_sw(12'h110, 5'd5, 5'd0), 3, 1, 32'h110, 32'h1234_5673);
		rows[12] = make_row(enc_r(7'h20, 5'd4, 5'd3, 3'b000, 5'd6), 3, 0, 0, 0);
		rows[13] = make_row(enc_sw(12'h114, 5'd6, 5'd0), 3, 1, 32'h114, 32'hEDCB_AA87);
		rows[14] = make_row(enc_r(7'h00, 5'd2, 5'd4, 3'b111, 5'd7), 3, 0, 0, 0);
		rows[15] = make_row(enc_r(7'h00, 5'd7, 5'd3, 3'b110, 5'd8), 3, 0, 0, 0);
		rows[16] = make_row(enc_sw(12'h118, 5'd8, 5'd0), 3, 1, 32'h118, 32'h1234_56FF);
		rows[17] = make_row(enc_r(7'h00, 5'd1, 5'd4, 3'b100, 5'd9), 3, 0, 0, 0);
		rows[18] = make_row(enc_sw(12'h11C, 5'd9, 5'd0), 3, 1, 32'h11C, 32'hEDCB_A983);
		rows[19] = make_row(enc_r(7'h00, 5'd4, 5'd4, 3'b000, 5'd0), 3, 0, 0, 0);
		rows[20] = make_row(enc_sw(12'h120, 5'd0, 5'd0), 3, 1, 32'h120, 32'h0);
		// Test 4, offsets around a base register
		rows[21] = make_row(enc_i(12'h200, 5'd0, 3'b000, 5'd10), 4, 0, 0, 0);
		rows[22] = make_row(enc_sw(12'h010, 5'd4, 5'd10), 4, 1, 32'h210, 32'h1234_5678);
		rows[23] = make_row(enc_sw(12'hFF8, 5'd5, 5'd10), 4, 1, 32'h1F8, 32'h1234_5673);
		// Test 5, unknown opcode aimed at x9
		rows[24] = make_row({20'hABCDE, 5'd9, 7'b1111111}, 5, 0, 0, 0);
		rows[25] = make_row(enc_sw(12'h124, 5'd9, 5'd0), 5, 1, 32'h124, 32'hEDCB_A983);
		rows[26] = make_row(enc_sw(12'h128, 5'd3, 5'd0), 5, 1, 32'h128, 32'h0000_00FF);
		// Test 6, more traffic under random delays
		rows[27] = make_row(enc_i(12'h7FF, 5'd9, 3'b100, 5'd11), 6, 0, 0, 0);
		rows[28] = make_row(enc_sw(12'hFFC, 5'd11, 5'd10), 6, 1, 32'h1FC, 32'hEDCB_AE7C);
	endtask

	// Run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the core stopped making progress after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	initial
	begin
		logic [63:0] d0;
		logic [63:0] d1;
		logic [31:0] pc;
		int          test_errors;

		l15_transducer_ack = 1'b0;
		l15_transducer_header_ack = 1'b0;
		l15_transducer_val = 1'b0;
		l15_transducer_data_0 = '0;
		l15_transducer_data_1 = '0;
		l15_transducer_returntype = '0;
		load_table();

		@(posedge nrst);
		step();

		// Test 1, early loads are acked and dropped, then wake-up
		test_errors = errors;
		for (int k = 0; k < 3; k++)
		begin
			make_lines(RESET_PC, 32'h0, d0, d1);
			send_response(pkg_instructions::RET_LOAD, d0, d1);
			repeat (2) step();
			check_value("transducer_l15_val", {31'b0, transducer_l15_val}, 32'h0);
		end
		send_response(pkg_instructions::RET_INT, '0, '0);
		wait_request();
		check_value("transducer_l15_address", transducer_l15_address, RESET_PC);
		check_value("transducer_l15_rqtype", {27'b0, transducer_l15_rqtype},
			{27'b0, pkg_instructions::RQ_LOAD});
		check_value("transducer_l15_size", {29'b0, transducer_l15_size},
			{29'b0, pkg_instructions::SIZE_WORD});
		tests_run++;
		$display("Test 1 finished with %0d errors", errors - test_errors);

		test_errors = errors;
		pc = RESET_PC;
		for (int i = 0; i < NUM_ROWS; i++)
		begin
			// Fetch at pc
			wait_request();
			check_value("transducer_l15_rqtype", {27'b0, transducer_l15_rqtype},
				{27'b0, pkg_instructions::RQ_LOAD});
			check_value("transducer_l15_address", transducer_l15_address, pc);
			accept_request();
			make_lines(pc, rows[i].word, d0, d1);
			send_response(pkg_instructions::RET_LOAD, d0, d1);

			if (rows[i].store)
			begin
				wait_request();
				check_value("transducer_l15_rqtype", {27'b0, transducer_l15_rqtype},
					{27'b0, pkg_instructions::RQ_STORE});
				check_value("transducer_l15_address", transducer_l15_address, rows[i].addr);
				check_value("transducer_l15_data", transducer_l15_data, rows[i].data);
				accept_request();
				make_lines(rows[i].addr, 32'h0, d0, d1);
				send_response(pkg_instructions::RET_ST_ACK, d0, d1);
			end
			pc = pc + 32'd4;

			if (i == NUM_ROWS - 1 || rows[i + 1].test != rows[i].test)
			begin
				// Last row's retire shows up as the next fetch
				if (i == NUM_ROWS - 1)
				begin
					wait_request();
					check_value("transducer_l15_address", transducer_l15_address, pc);
				end
				tests_run++;
				$display("Test %0d finished with %0d errors", rows[i].test,
					errors - test_errors);
				test_errors = errors;
			end
		end

		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== vlog.f ====
pkg_instructions.sv
core_mem_if.sv
l15_transducer.sv
instr_decode.sv
execute_unit.sv
core.sv
core_checker.sv
tb_clock.sv
tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_STR  ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status comes from the search for the pass line
run: build
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF '$(PASS_STR)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
